// File: rtl/lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// datapath word and address width
`define LC3B_WORD_W 16

// architectural register count
`define LC3B_NREG 8

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

`endif

// File: rtl/lc3b_types.sv
`default_nettype none

`include "lc3b_cfg.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NREG)-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;                    // n, z, p

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // second ALU operand source
    typedef enum logic [1:0] {
        alumux_reg,
        alumux_sext5,
        alumux_sext6
    } lc3b_alumux;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } lc3b_fwd_sel;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop aluop;
        lc3b_alumux alumux_sel;
        logic load_regfile;
        logic mem_read;
        logic mem_write;
        logic load_cc;
        logic is_br;
        logic is_nop;
    } lc3b_ctrl_word;

    localparam lc3b_ctrl_word ctrl_nop = '{opcode: op_br, aluop: alu_pass,
                                           alumux_sel: alumux_reg, is_nop: 1'b1,
                                           default: 1'b0};

    // decode -> execute
    typedef struct packed {
        lc3b_ctrl_word ctrl;
        lc3b_word sr1_val;
        lc3b_word sr2_val;
        lc3b_reg sr1;
        lc3b_reg sr2;
        lc3b_reg dest;
        lc3b_word imm5;                              // sext5
        lc3b_word off6;                              // sext6, word scaled
        lc3b_nzp br_nzp;
        lc3b_word br_target;
    } lc3b_ex_payload;

    // execute -> memory
    typedef struct packed {
        lc3b_ctrl_word ctrl;
        lc3b_word alu_result;                        // also the data address
        lc3b_word store_data;
        lc3b_reg dest;
        lc3b_nzp nzp;                                // branch mask or result codes
        lc3b_word br_target;
    } lc3b_mem_payload;

    // memory -> writeback
    typedef struct packed {
        lc3b_ctrl_word ctrl;
        lc3b_word value;
        lc3b_reg dest;
    } lc3b_wb_payload;

endpackage : lc3b_types

`default_nettype wire

// File: rtl/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg
#(
    parameter type payload_t = logic,
    parameter payload_t bubble = '0
)
(
    input logic clk,
    input logic reset,
    input logic load,
    input logic flush,
    input payload_t in,
    output payload_t out
);

    always_ff @(posedge clk)
    begin
        if (reset)
            out <= bubble;
        else if (load)
            out <= flush ? bubble : in;            // squashed slot becomes a nop
    end

endmodule : stage_reg

`default_nettype wire

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
(
    input logic clk,
    input logic reset,
    input logic load,
    input logic flush,
    input lc3b_types::lc3b_word instr_rdata,
    output lc3b_types::lc3b_ctrl_word ctrl,
    output lc3b_types::lc3b_reg sr1,
    output lc3b_types::lc3b_reg sr2,
    output lc3b_types::lc3b_reg dest,
    output lc3b_types::lc3b_word ir
);

    import lc3b_types::*;

    lc3b_word ir_q;
    logic imm;

    always_ff @(posedge clk)
    begin
        if (reset)
            ir_q <= '0;
        else if (load)
            ir_q <= flush ? '0 : instr_rdata;     // zero word decodes as nop
    end

    assign ir = ir_q;
    assign imm = ir_q[5];
    assign sr1 = ir_q[8:6];
    assign dest = ir_q[11:9];
    assign sr2 = (ir_q[15:12] == op_str) ? ir_q[11:9] : ir_q[2:0]; // str data reg

    // control rom
    always_comb
    begin
        ctrl = ctrl_nop;
        case (ir_q[15:12])
            op_add, op_and:
            begin
                ctrl.opcode = (ir_q[15:12] == op_add) ? op_add : op_and;
                ctrl.aluop = (ir_q[15:12] == op_add) ? alu_add : alu_and;
                ctrl.alumux_sel = imm ? alumux_sext5 : alumux_reg;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.is_nop = 1'b0;
            end
            op_not:
            begin
                ctrl.opcode = op_not;
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.is_nop = 1'b0;
            end
            op_ldr:
            begin
                ctrl.opcode = op_ldr;
                ctrl.aluop = alu_add;                // base + offset
                ctrl.alumux_sel = alumux_sext6;
                ctrl.mem_read = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.is_nop = 1'b0;
            end
            op_str:
            begin
                ctrl.opcode = op_str;
                ctrl.aluop = alu_add;
                ctrl.alumux_sel = alumux_sext6;
                ctrl.mem_write = 1'b1;
                ctrl.is_nop = 1'b0;
            end
            op_br:
            begin
                ctrl.is_br = 1'b1;
                ctrl.is_nop = (ir_q[11:9] == 3'b000); // never taken
            end
            default:
                ctrl = ctrl_nop;                      // unsupported opcodes
        endcase
    end

endmodule : instr_decoder

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module regfile
(
    input logic clk,
    input logic reset,
    input logic load,
    input lc3b_types::lc3b_reg dest,
    input lc3b_types::lc3b_word in,
    input lc3b_types::lc3b_reg src_a,
    input lc3b_types::lc3b_reg src_b,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    import lc3b_types::*;

    lc3b_word data [`LC3B_NREG];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `LC3B_NREG; i++)
                data[i] <= '0;
        end
        else if (load)
            data[dest] <= in;
    end

    // same-cycle writeback goes straight through
    assign reg_a = (load && (dest == src_a)) ? in : data[src_a];
    assign reg_b = (load && (dest == src_b)) ? in : data[src_b];

endmodule : regfile

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
(
    input lc3b_types::lc3b_aluop aluop,
    input lc3b_types::lc3b_word a,
    input lc3b_types::lc3b_word b,
    output lc3b_types::lc3b_word f,
    output lc3b_types::lc3b_nzp nzp
);

    import lc3b_types::*;

    always_comb
    begin
        case (aluop)
            alu_add: f = a + b;
            alu_and: f = a & b;
            alu_not: f = ~a;
            default: f = a;                          // pass
        endcase
    end

    // condition codes of the result
    assign nzp = {f[$bits(lc3b_word)-1], (f == '0), (!f[$bits(lc3b_word)-1] && (f != '0))};

endmodule : alu

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
(
    input lc3b_types::lc3b_reg dec_sr1,
    input lc3b_types::lc3b_reg dec_sr2,
    input lc3b_types::lc3b_ctrl_word dec_ctrl,
    input lc3b_types::lc3b_ex_payload ex,
    input lc3b_types::lc3b_mem_payload mem,
    input lc3b_types::lc3b_wb_payload wb,
    output logic bubble,
    output lc3b_types::lc3b_fwd_sel fwd_a,
    output lc3b_types::lc3b_fwd_sel fwd_b
);

    import lc3b_types::*;

    logic use_sr1;
    logic use_sr2;
    logic ld_hit;

    // younger memory stage wins over writeback
    function automatic lc3b_fwd_sel pick(input lc3b_reg src);
        if (mem.ctrl.load_regfile && !mem.ctrl.is_nop && (mem.dest == src))
            return fwd_mem;
        else if (wb.ctrl.load_regfile && !wb.ctrl.is_nop && (wb.dest == src))
            return fwd_wb;
        else
            return fwd_none;
    endfunction

    always_comb
    begin
        use_sr1 = !dec_ctrl.is_nop && !dec_ctrl.is_br;
        use_sr2 = !dec_ctrl.is_nop && !dec_ctrl.is_br
                  && (dec_ctrl.mem_write
                      || ((dec_ctrl.alumux_sel == alumux_reg) && (dec_ctrl.aluop != alu_not)));
        ld_hit = !ex.ctrl.is_nop && (ex.ctrl.opcode == op_ldr);

        // load data only exists after the memory stage
        bubble = ld_hit && ((use_sr1 && (ex.dest == dec_sr1))
                            || (use_sr2 && (ex.dest == dec_sr2)));

        fwd_a = pick(ex.sr1);
        fwd_b = pick(ex.sr2);                        // alu operand and store data
    end

endmodule : hazard_unit

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module datapath
(
    input logic clk,
    input logic reset,
    output logic instr_read,
    output lc3b_types::lc3b_word instr_address,
    input lc3b_types::lc3b_word instr_rdata,
    input logic i_mem_resp,
    output logic mem_read,
    output logic mem_write,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_word mem_wdata,
    input lc3b_types::lc3b_word mem_rdata,
    input logic d_mem_resp
);

    import lc3b_types::*;

    localparam lc3b_ex_payload ex_bubble = '{ctrl: ctrl_nop, default: '0};
    localparam lc3b_mem_payload mem_bubble = '{ctrl: ctrl_nop, default: '0};
    localparam lc3b_wb_payload wb_bubble = '{ctrl: ctrl_nop, default: '0};

    logic fetch_on;
    logic stage_load;
    logic bubble;
    logic flush;
    lc3b_word pc;
    lc3b_nzp cc;
    lc3b_word ir;
    lc3b_ctrl_word dec_ctrl;
    lc3b_reg dec_sr1;
    lc3b_reg dec_sr2;
    lc3b_reg dec_dest;
    lc3b_word reg_a;
    lc3b_word reg_b;
    lc3b_ex_payload ex_in;
    lc3b_ex_payload ex;
    lc3b_mem_payload mem_in;
    lc3b_mem_payload mem;
    lc3b_wb_payload wb_in;
    lc3b_wb_payload wb;
    lc3b_fwd_sel fwd_a;
    lc3b_fwd_sel fwd_b;
    lc3b_word opnd_a;
    lc3b_word opnd_b;
    lc3b_word alu_b;
    lc3b_word alu_f;
    lc3b_nzp alu_nzp;
    lc3b_word ld_data;
    lc3b_nzp ld_nzp;

    always_ff @(posedge clk)
    begin
        if (reset)
            fetch_on <= 1'b0;
        else
            fetch_on <= 1'b1;
    end

    // both ports must answer before anything moves
    assign stage_load = fetch_on && i_mem_resp
                        && (d_mem_resp || !(mem.ctrl.mem_read || mem.ctrl.mem_write));
    assign flush = mem.ctrl.is_br && (|(mem.nzp & cc)); // taken branch
    assign instr_read = fetch_on;
    assign instr_address = pc;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `LC3B_RESET_PC;
        else if (stage_load && flush)
            pc <= mem.br_target;
        else if (stage_load && !bubble)
            pc <= pc + lc3b_word'(2);
    end

    instr_decoder instr_decoder_inst
    (
        .clk(clk),
        .reset(reset),
        .load(stage_load && (!bubble || flush)),
        .flush(flush),
        .instr_rdata(instr_rdata),
        .ctrl(dec_ctrl),
        .sr1(dec_sr1),
        .sr2(dec_sr2),
        .dest(dec_dest),
        .ir(ir)
    );

    regfile regfile_inst
    (
        .clk(clk),
        .reset(reset),
        .load(wb.ctrl.load_regfile),
        .dest(wb.dest),
        .in(wb.value),
        .src_a(dec_sr1),
        .src_b(dec_sr2),
        .reg_a(reg_a),
        .reg_b(reg_b)
    );

    hazard_unit hazard_unit_inst
    (
        .dec_sr1(dec_sr1),
        .dec_sr2(dec_sr2),
        .dec_ctrl(dec_ctrl),
        .ex(ex),
        .mem(mem),
        .wb(wb),
        .bubble(bubble),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

    always_comb
    begin
        ex_in.ctrl = dec_ctrl;
        ex_in.sr1_val = reg_a;
        ex_in.sr2_val = reg_b;
        ex_in.sr1 = dec_sr1;
        ex_in.sr2 = dec_sr2;
        ex_in.dest = dec_dest;
        ex_in.imm5 = lc3b_word'($signed(ir[4:0]));
        ex_in.off6 = lc3b_word'($signed(ir[5:0])) << 1;
        ex_in.br_nzp = ir[11:9];
        ex_in.br_target = pc + (lc3b_word'($signed(ir[8:0])) << 1); // pc already +2
    end

    stage_reg #(.payload_t(lc3b_ex_payload), .bubble(ex_bubble)) ex_stage
    (
        .clk(clk),
        .reset(reset),
        .load(stage_load),
        .flush(flush || bubble),                     // load-use slot gets a nop
        .in(ex_in),
        .out(ex)
    );

    always_comb
    begin
        case (fwd_a)
            fwd_mem: opnd_a = mem.alu_result;
            fwd_wb: opnd_a = wb.value;
            default: opnd_a = ex.sr1_val;
        endcase
        case (fwd_b)
            fwd_mem: opnd_b = mem.alu_result;
            fwd_wb: opnd_b = wb.value;
            default: opnd_b = ex.sr2_val;
        endcase
        case (ex.ctrl.alumux_sel)
            alumux_sext5: alu_b = ex.imm5;
            alumux_sext6: alu_b = ex.off6;
            default: alu_b = opnd_b;
        endcase
    end

    alu alu_inst
    (
        .aluop(ex.ctrl.aluop),
        .a(opnd_a),
        .b(alu_b),
        .f(alu_f),
        .nzp(alu_nzp)
    );

    always_comb
    begin
        mem_in.ctrl = ex.ctrl;
        mem_in.alu_result = alu_f;
        mem_in.store_data = opnd_b;
        mem_in.dest = ex.dest;
        mem_in.nzp = ex.ctrl.is_br ? ex.br_nzp : alu_nzp;
        mem_in.br_target = ex.br_target;
    end

    stage_reg #(.payload_t(lc3b_mem_payload), .bubble(mem_bubble)) mem_stage
    (
        .clk(clk),
        .reset(reset),
        .load(stage_load),
        .flush(flush),
        .in(mem_in),
        .out(mem)
    );

    assign mem_read = mem.ctrl.mem_read;
    assign mem_write = mem.ctrl.mem_write;
    assign mem_address = mem.alu_result;
    assign mem_wdata = mem.store_data;

    // condition codes for loaded data
    alu ld_gencc
    (
        .aluop(alu_pass),
        .a(mem_rdata),
        .b('0),
        .f(ld_data),
        .nzp(ld_nzp)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
            cc <= 3'b010;
        else if (stage_load && mem.ctrl.load_cc)
            cc <= mem.ctrl.mem_read ? ld_nzp : mem.nzp;
    end

    always_comb
    begin
        wb_in.ctrl = mem.ctrl;
        wb_in.value = mem.ctrl.mem_read ? ld_data : mem.alu_result;
        wb_in.dest = mem.dest;
    end

    stage_reg #(.payload_t(lc3b_wb_payload), .bubble(wb_bubble)) wb_stage
    (
        .clk(clk),
        .reset(reset),
        .load(stage_load),
        .flush(1'b0),                                // branch itself retires
        .in(wb_in),
        .out(wb)
    );

endmodule : datapath

`default_nettype wire

// File: rtl/lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_core
(
    input logic clk,
    input logic reset,
    output logic instr_read,
    output lc3b_types::lc3b_word instr_address,
    input lc3b_types::lc3b_word instr_rdata,
    input logic i_mem_resp,
    output logic mem_read,
    output logic mem_write,
    output lc3b_types::lc3b_word mem_address,
    output lc3b_types::lc3b_word mem_wdata,
    input lc3b_types::lc3b_word mem_rdata,
    input logic d_mem_resp
);

    datapath datapath_inst
    (
        .clk(clk),
        .reset(reset),
        .instr_read(instr_read),
        .instr_address(instr_address),
        .instr_rdata(instr_rdata),
        .i_mem_resp(i_mem_resp),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .d_mem_resp(d_mem_resp)
    );

endmodule : lc3b_core

`default_nettype wire

// File: test/tb_lc3b_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module tb_lc3b_core;

    import lc3b_types::*;

    localparam int prog_len = 30;
    localparam int dmem_words = 64;
    localparam int tail_len = 3;                     // younger slots still in flight

    logic clk;
    logic reset;
    logic instr_read;
    logic i_mem_resp;
    logic mem_read;
    logic mem_write;
    logic d_mem_resp;
    lc3b_word instr_address;
    lc3b_word instr_rdata;
    lc3b_word mem_address;
    lc3b_word mem_wdata;
    lc3b_word mem_rdata;

    lc3b_word prog [prog_len];
    lc3b_word dmem [dmem_words];
    lc3b_word model_mem [dmem_words];
    lc3b_word model_regs [`LC3B_NREG];
    lc3b_word exp_addr [$];
    lc3b_word exp_data [$];
    logic [31:0] rng;
    logic [1:0] i_wait;
    logic [1:0] d_wait;
    logic adv;                                       // pipeline moves at next edge
    int stores_seen;
    int tail_moves;

    lc3b_core lc3b_core_inst
    (
        .clk(clk),
        .reset(reset),
        .instr_read(instr_read),
        .instr_address(instr_address),
        .instr_rdata(instr_rdata),
        .i_mem_resp(i_mem_resp),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .d_mem_resp(d_mem_resp)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic lc3b_word fill_word(input int i);
        return lc3b_word'(i * 16'h0245) ^ 16'h8c31;
    endfunction

    function automatic lc3b_word fetch_word(input lc3b_word addr);
        if ((addr >> 1) < prog_len)
            return prog[addr >> 1];
        else
            return '0;                               // past the end reads as nop
    endfunction

    function automatic lc3b_nzp nzp_of(input lc3b_word v);
        if (v == '0)
            return 3'b010;
        else if (v[`LC3B_WORD_W-1])
            return 3'b100;
        else
            return 3'b001;
    endfunction

    task automatic check_word(input string what, input lc3b_word got, input lc3b_word exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_ctrl(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "control mismatch");
        end
    endtask

    // in-order ISA model that builds the expected store list
    task automatic run_isa_model();
        lc3b_word pc;
        lc3b_word ir;
        lc3b_word opnd;
        lc3b_word res;
        lc3b_word addr;
        lc3b_nzp cc;
        int steps;
        pc = `LC3B_RESET_PC;
        cc = 3'b010;
        steps = 0;
        for (int r = 0; r < `LC3B_NREG; r++)
            model_regs[r] = '0;
        while (((pc >> 1) < prog_len) && (steps < 4 * prog_len))
        begin
            ir = prog[pc >> 1];
            pc = pc + 16'd2;
            steps++;
            opnd = ir[5] ? lc3b_word'($signed(ir[4:0])) : model_regs[ir[2:0]];
            addr = model_regs[ir[8:6]] + (lc3b_word'($signed(ir[5:0])) << 1);
            case (ir[15:12])
                op_add: res = model_regs[ir[8:6]] + opnd;
                op_and: res = model_regs[ir[8:6]] & opnd;
                op_not: res = ~model_regs[ir[8:6]];
                op_ldr: res = model_mem[addr[6:1]];
                default: res = '0;
            endcase
            case (ir[15:12])
                op_add, op_and, op_not, op_ldr:
                begin
                    model_regs[ir[11:9]] = res;
                    cc = nzp_of(res);
                end
                op_str:
                begin
                    model_mem[addr[6:1]] = model_regs[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(model_regs[ir[11:9]]);
                end
                op_br:
                    if ((ir[11:9] & cc) != 3'b000)
                        pc = pc + (lc3b_word'($signed(ir[8:0])) << 1);
                default: ;
            endcase
        end
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        instr_rdata = '0;
        i_mem_resp = 1'b0;
        mem_rdata = '0;
        d_mem_resp = 1'b0;
        rng = 32'hf6b9;
        i_wait = '0;
        d_wait = '0;
        adv = 1'b0;
        stores_seen = 0;
        tail_moves = 0;
        prog = '{
            16'h1227, 16'h147d, 16'h5681, 16'h98ff,  // dependent alu chain
            16'h1b02, 16'h5d7e, 16'h7c0a,
            16'h620a, 16'h1445, 16'h740b,            // load then dependent add
            16'h6603, 16'h760c,                      // load into store data
            16'h1e20, 16'h0402, 16'h1fe1, 16'h720d,  // brz skips the next two
            16'h1fe5, 16'h0801, 16'h1fe2,            // brn falls through
            16'h0e01, 16'h7e0e, 16'h1d87,
            16'h7010, 16'h7211, 16'h7412, 16'h7613,  // dump all registers
            16'h7814, 16'h7a15, 16'h7c16, 16'h7e17
        };
        for (int i = 0; i < dmem_words; i++)
        begin
            dmem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        run_isa_model();
        repeat (2) @(posedge clk);
        #1;
        check_ctrl("instr_read in reset", instr_read, 1'b0);
        check_ctrl("mem_read in reset", mem_read, 1'b0);
        check_ctrl("mem_write in reset", mem_write, 1'b0);
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_ctrl("instr_read after reset", instr_read, 1'b1);
        check_word("first fetch address", instr_address, `LC3B_RESET_PC);
        wait (tail_moves == tail_len);
        $display("%0d stores matched the ISA model", stores_seen);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // resp comes 0 to 3 cycles late and stays up until the pipeline moves
    always @(posedge clk)
    begin
        #1;
        if (adv)
        begin
            rng = xorshift32(rng);
            i_wait = rng[1:0];
            rng = xorshift32(rng);
            d_wait = rng[1:0];
        end
        else
        begin
            if (i_wait != 0)
                i_wait--;
            if ((d_wait != 0) && (mem_read || mem_write))
                d_wait--;
        end
        i_mem_resp = instr_read && (i_wait == 0);
        instr_rdata = fetch_word(instr_address);
        d_mem_resp = (mem_read || mem_write) && (d_wait == 0);
        mem_rdata = dmem[mem_address[6:1]];
    end

    always @(negedge clk)
    begin
        adv = instr_read && i_mem_resp && (d_mem_resp || !(mem_read || mem_write));
        if (adv && mem_write)
        begin
            if (exp_addr.size() == 0)
            begin
                $display("store to %h seen after the last expected store", mem_address);
                $display("TEST RESULT: FAIL");
                $fatal(1, "unexpected store");
            end
            else
            begin
                check_word("store address", mem_address, exp_addr.pop_front());
                check_word("store data", mem_wdata, exp_data.pop_front());
                dmem[mem_address[6:1]] = mem_wdata;
                stores_seen++;
            end
        end
        else if (adv && (exp_addr.size() == 0))
            tail_moves++;                            // slot behind the last store drained
    end

    initial
    begin
        #(prog_len * 4 * 20 * 8);
        $display("watchdog expired with %0d stores still missing", exp_addr.size());
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule : tb_lc3b_core

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/lc3b_types.sv
rtl/stage_reg.sv
rtl/instr_decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/datapath.sv
rtl/lc3b_core.sv
test/tb_lc3b_core.sv
